//--- Bender.yml
package:
  name: host_chan_as_ccip

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/ccip_shim_pkg.sv
      - hw/ccip_rob.sv
      - hw/ccip_reg_stage.sv
      - hw/host_chan_as_ccip.sv
  - target: test
    include_dirs:
      - hw
      - test
    files:
      - test/host_chan_as_ccip_tb.sv

//--- host_chan_as_ccip.f
+incdir+hw
+incdir+test
hw/ccip_shim_pkg.sv
hw/ccip_rob.sv
hw/ccip_reg_stage.sv
hw/host_chan_as_ccip.sv
test/host_chan_as_ccip_tb.sv

//--- hw/ccip_reg_stage.sv
`timescale 1ns/1ps

`include "ccip_shim_macros.svh"

// FIU-side register pipeline shared by both channels
// Every field moves through N_STAGES registers in both directions
module ccip_reg_stage
#(
    parameter int N_STAGES = `CCIP_REG_STAGES
)
(
    input  logic clk,
    input  logic reset,

    // Renamed requests from the two reorder buffers
    input  logic c0_alloc_valid,
    input  logic [`CCIP_ROB_IDX_W-1:0] c0_alloc_idx,
    input  ccip_shim_pkg::ccip_addr_t c0_addr,
    input  logic c1_alloc_valid,
    input  logic [`CCIP_ROB_IDX_W-1:0] c1_alloc_idx,
    input  ccip_shim_pkg::ccip_addr_t c1_addr,
    input  ccip_shim_pkg::ccip_line_t c1_data,

    // Host responses and almost-full levels
    input  logic fiu_c0_rx_valid,
    input  ccip_shim_pkg::ccip_mdata_t fiu_c0_rx_mdata,
    input  ccip_shim_pkg::ccip_line_t fiu_c0_rx_data,
    input  logic fiu_c1_rx_valid,
    input  ccip_shim_pkg::ccip_mdata_t fiu_c1_rx_mdata,
    input  logic fiu_c1_rx_hit_miss,
    input  logic [1:0] fiu_c1_rx_vc_used,
    input  logic fiu_c0_almost_full,
    input  logic fiu_c1_almost_full,

    // Requests toward the host
    output logic fiu_c0_tx_valid,
    output ccip_shim_pkg::ccip_addr_t fiu_c0_tx_addr,
    output ccip_shim_pkg::ccip_mdata_t fiu_c0_tx_mdata,
    output logic fiu_c1_tx_valid,
    output ccip_shim_pkg::ccip_addr_t fiu_c1_tx_addr,
    output ccip_shim_pkg::ccip_line_t fiu_c1_tx_data,
    output ccip_shim_pkg::ccip_mdata_t fiu_c1_tx_mdata,

    // Registered fills toward the reorder buffers
    output logic c0_fill_valid,
    output logic [`CCIP_ROB_IDX_W-1:0] c0_fill_idx,
    output ccip_shim_pkg::ccip_line_t c0_fill_data,
    output logic c1_fill_valid,
    output logic [`CCIP_ROB_IDX_W-1:0] c1_fill_idx,
    output ccip_shim_pkg::ccip_wr_rsp_t c1_fill_rsp,

    // Delayed FIU almost-full levels
    output logic c0_fiu_af,
    output logic c1_fiu_af
);

    import ccip_shim_pkg::*;

    localparam int IDX_W = `CCIP_ROB_IDX_W;
    localparam int CTRL_W = 6;
    localparam int DATA_W = 2 * $bits(ccip_addr_t) + 2 * $bits(ccip_line_t) +
                            4 * IDX_W + $bits(ccip_wr_rsp_t);

    // Write response fields gathered into the payload type before staging
    ccip_wr_rsp_t c1_rsp_in;

    // Slot indices leaving the pipe, widened to the tag width below
    logic [IDX_W-1:0] c0_tx_idx;
    logic [IDX_W-1:0] c1_tx_idx;

    // Control bits are reset, payload bits are not
    logic [CTRL_W-1:0] ctrl_in;
    logic [DATA_W-1:0] data_in;
    logic [CTRL_W-1:0] ctrl_q [N_STAGES];
    logic [DATA_W-1:0] data_q [N_STAGES];

    assign c1_rsp_in.hit_miss = fiu_c1_rx_hit_miss;
    assign c1_rsp_in.vc_used = fiu_c1_rx_vc_used;

    // ========================================
    // Pack both directions
    // ========================================

    assign ctrl_in = {c0_alloc_valid, c1_alloc_valid, fiu_c0_rx_valid,
                      fiu_c1_rx_valid, fiu_c0_almost_full, fiu_c1_almost_full};

    // The host echoes the slot index in the low bits of mdata
    assign data_in = {c0_addr, c0_alloc_idx, c1_addr, c1_data, c1_alloc_idx,
                      fiu_c0_rx_mdata[IDX_W-1:0], fiu_c0_rx_data,
                      fiu_c1_rx_mdata[IDX_W-1:0], c1_rsp_in};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < N_STAGES; i++)
            begin
                ctrl_q[i] <= '0;
            end
        end
        else
        begin
            ctrl_q[0] <= ctrl_in;
            for (int i = 1; i < N_STAGES; i++)
            begin
                ctrl_q[i] <= ctrl_q[i-1];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        data_q[0] <= data_in;
        for (int i = 1; i < N_STAGES; i++)
        begin
            data_q[i] <= data_q[i-1];
        end
    end

    // ========================================
    // Unpack the last stage
    // ========================================

    assign {fiu_c0_tx_valid, fiu_c1_tx_valid, c0_fill_valid,
            c1_fill_valid, c0_fiu_af, c1_fiu_af} = ctrl_q[N_STAGES-1];

    assign {fiu_c0_tx_addr, c0_tx_idx, fiu_c1_tx_addr, fiu_c1_tx_data, c1_tx_idx,
            c0_fill_idx, c0_fill_data, c1_fill_idx, c1_fill_rsp} = data_q[N_STAGES-1];

    // Slot index goes out zero-extended in the tag field
    assign fiu_c0_tx_mdata = {{($bits(ccip_mdata_t) - IDX_W){1'b0}}, c0_tx_idx};
    assign fiu_c1_tx_mdata = {{($bits(ccip_mdata_t) - IDX_W){1'b0}}, c1_tx_idx};

endmodule

//--- hw/ccip_rob.sv
`timescale 1ns/1ps

`include "ccip_shim_macros.svh"

// Reorder buffer for one CCI-P channel
// Requests are renamed to a slot index on the way to the host, and responses
// that come back in any order are released to the AFU in request order
module ccip_rob
#(
    parameter type payload_t = ccip_shim_pkg::ccip_line_t,
    parameter int DEPTH = `CCIP_ROB_DEPTH
)
(
    input  logic clk,
    input  logic reset,

    // AFU request strobe and its original tag
    input  logic req_valid,
    input  ccip_shim_pkg::ccip_mdata_t req_mdata,

    // FIU almost-full level, already delayed by the register stages
    input  logic fiu_almost_full,

    // Renamed request toward the register stages
    output logic alloc_valid,
    output logic [`CCIP_ROB_IDX_W-1:0] alloc_idx,
    output logic almost_full,

    // Host response, with the slot index it was tagged with
    input  logic fill_valid,
    input  logic [`CCIP_ROB_IDX_W-1:0] fill_idx,
    input  payload_t fill_payload,

    // In-order response toward the AFU
    output logic rsp_valid,
    output payload_t rsp_payload,
    output ccip_shim_pkg::ccip_mdata_t rsp_mdata
);

    import ccip_shim_pkg::*;

    localparam int IDX_W = `CCIP_ROB_IDX_W;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Oldest allocated slot and next slot to allocate
    logic [IDX_W-1:0] head;
    logic [IDX_W-1:0] tail;

    // Number of slots not holding a request
    logic [CNT_W-1:0] free_cnt;

    // Set when the slot's response has arrived and is waiting to drain
    logic [DEPTH-1:0] ready;

    // Per-slot storage for the host payload and the AFU tag
    payload_t data_mem [DEPTH];
    ccip_mdata_t tag_mem [DEPTH];

    // A fill that lands on the head slot can drain in the same cycle
    logic fill_hits_head;
    logic drain;

    // Advance a slot pointer with wrap at DEPTH
    function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
        if (idx == IDX_W'(DEPTH - 1))
        begin
            return '0;
        end
        return idx + 1'b1;
    endfunction

    // ========================================
    // Allocation
    // ========================================

    // The renamed request leaves in the same cycle, so the register stages
    // alone set the request latency toward the FIU
    assign alloc_valid = req_valid;
    assign alloc_idx = tail;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tail <= '0;
        end
        else if (req_valid)
        begin
            tail <= next_idx(tail);
        end
    end

    // Keep the AFU tag until the response is released
    always_ff @(posedge clk)
    begin
        if (req_valid)
        begin
            tag_mem[tail] <= req_mdata;
        end
    end

    // ========================================
    // Fill
    // ========================================

    always_ff @(posedge clk)
    begin
        if (fill_valid)
        begin
            data_mem[fill_idx] <= fill_payload;
        end
    end

    assign fill_hits_head = fill_valid && (fill_idx == head);

    // Head is drained either from a stored response or straight from the fill
    assign drain = ready[head] || fill_hits_head;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ready <= '0;
        end
        else
        begin
            // A fill that bypasses to the output never marks its slot
            if (fill_valid && !fill_hits_head)
            begin
                ready[fill_idx] <= 1'b1;
            end

            if (drain)
            begin
                ready[head] <= 1'b0;
            end
        end
    end

    // ========================================
    // In-order drain
    // ========================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp_valid <= 1'b0;
            head <= '0;
        end
        else
        begin
            rsp_valid <= drain;
            if (drain)
            begin
                head <= next_idx(head);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (drain)
        begin
            rsp_payload <= ready[head] ? data_mem[head] : fill_payload;
            rsp_mdata <= tag_mem[head];
        end
    end

    // ========================================
    // Flow control
    // ========================================

    // Allocation takes a slot and the drain returns one, possibly both at once
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            free_cnt <= CNT_W'(DEPTH);
        end
        else
        begin
            case ({req_valid, drain})
                2'b10: free_cnt <= free_cnt - 1'b1;
                2'b01: free_cnt <= free_cnt + 1'b1;
                default: free_cnt <= free_cnt;
            endcase
        end
    end

    // The AFU holds off when no slot is left or the host itself is filling up
    assign almost_full = (free_cnt == '0) || fiu_almost_full;

endmodule

//--- hw/ccip_shim_macros.svh
`ifndef CCIP_SHIM_MACROS_SVH
`define CCIP_SHIM_MACROS_SVH

// Slots in each reorder buffer, which bounds the requests in flight per channel
`define CCIP_ROB_DEPTH 16

// Width of a slot index, enough to address CCIP_ROB_DEPTH slots
`define CCIP_ROB_IDX_W 4

// Default number of FIU-side register stages
`define CCIP_REG_STAGES 1

// Narrowed CCI-P field widths
`define CCIP_ADDR_W 16
`define CCIP_LINE_W 64
`define CCIP_MDATA_W 16

`endif

//--- hw/ccip_shim_pkg.sv
`include "ccip_shim_macros.svh"

package ccip_shim_pkg;

    // ========================================
    // Request fields
    // ========================================

    // Line address, narrowed from the full CCI-P address
    typedef logic [`CCIP_ADDR_W-1:0] ccip_addr_t;

    // One data line, used for write data and as the read response payload
    typedef logic [`CCIP_LINE_W-1:0] ccip_line_t;

    // Metadata tag carried by a request and echoed back by its response
    // On the FIU side only the low slot index bits are meaningful
    typedef logic [`CCIP_MDATA_W-1:0] ccip_mdata_t;

    // ========================================
    // Response payloads
    // ========================================

    // Write response fields kept per slot until the write is released in order
    // Read responses need no struct since their payload is a plain line
    typedef struct packed
    {
        // Cache hit or miss reported by the host
        logic hit_miss;

        // Virtual channel the host used for the request
        logic [1:0] vc_used;
    } ccip_wr_rsp_t;

endpackage

//--- hw/host_chan_as_ccip.sv
`timescale 1ns/1ps

`include "ccip_shim_macros.svh"

// Host channel shim that presents CCI-P to the AFU with responses sorted
// in request order on both the read (c0) and write (c1) channels
module host_chan_as_ccip
#(
    // FIU-side register stages, which also delay the FIU almost-full level
    parameter int N_STAGES = `CCIP_REG_STAGES
)
(
    input  logic clk,
    input  logic reset,

    // AFU read requests
    input  logic c0_tx_valid,
    input  ccip_shim_pkg::ccip_addr_t c0_tx_addr,
    input  ccip_shim_pkg::ccip_mdata_t c0_tx_mdata,

    // AFU write requests
    input  logic c1_tx_valid,
    input  ccip_shim_pkg::ccip_addr_t c1_tx_addr,
    input  ccip_shim_pkg::ccip_line_t c1_tx_data,
    input  ccip_shim_pkg::ccip_mdata_t c1_tx_mdata,

    // In-order responses and flow control toward the AFU
    output logic c0_rx_valid,
    output ccip_shim_pkg::ccip_line_t c0_rx_data,
    output ccip_shim_pkg::ccip_mdata_t c0_rx_mdata,
    output logic c1_rx_valid,
    output logic c1_rx_hit_miss,
    output logic [1:0] c1_rx_vc_used,
    output ccip_shim_pkg::ccip_mdata_t c1_rx_mdata,
    output logic c0_tx_almost_full,
    output logic c1_tx_almost_full,

    // Requests toward the FIU, tagged with slot indices
    output logic fiu_c0_tx_valid,
    output ccip_shim_pkg::ccip_addr_t fiu_c0_tx_addr,
    output ccip_shim_pkg::ccip_mdata_t fiu_c0_tx_mdata,
    output logic fiu_c1_tx_valid,
    output ccip_shim_pkg::ccip_addr_t fiu_c1_tx_addr,
    output ccip_shim_pkg::ccip_line_t fiu_c1_tx_data,
    output ccip_shim_pkg::ccip_mdata_t fiu_c1_tx_mdata,

    // Unordered responses and almost-full levels from the FIU
    input  logic fiu_c0_rx_valid,
    input  ccip_shim_pkg::ccip_line_t fiu_c0_rx_data,
    input  ccip_shim_pkg::ccip_mdata_t fiu_c0_rx_mdata,
    input  logic fiu_c1_rx_valid,
    input  logic fiu_c1_rx_hit_miss,
    input  logic [1:0] fiu_c1_rx_vc_used,
    input  ccip_shim_pkg::ccip_mdata_t fiu_c1_rx_mdata,
    input  logic fiu_c0_almost_full,
    input  logic fiu_c1_almost_full
);

    import ccip_shim_pkg::*;

    // Renamed requests from each reorder buffer
    logic c0_alloc_valid;
    logic [`CCIP_ROB_IDX_W-1:0] c0_alloc_idx;
    logic c1_alloc_valid;
    logic [`CCIP_ROB_IDX_W-1:0] c1_alloc_idx;

    // Registered host responses back into the reorder buffers
    logic c0_fill_valid;
    logic [`CCIP_ROB_IDX_W-1:0] c0_fill_idx;
    ccip_line_t c0_fill_data;
    logic c1_fill_valid;
    logic [`CCIP_ROB_IDX_W-1:0] c1_fill_idx;
    ccip_wr_rsp_t c1_fill_rsp;

    // FIU almost-full after the register stages
    logic c0_fiu_af;
    logic c1_fiu_af;

    // Write response as it leaves the write reorder buffer
    ccip_wr_rsp_t c1_rx_rsp;

    // ========================================
    // Read channel reorder buffer
    // ========================================

    ccip_rob
    #(
        .payload_t(ccip_line_t)
    )
    rob_rd
    (
        .clk,
        .reset,
        .req_valid(c0_tx_valid),
        .req_mdata(c0_tx_mdata),
        .fiu_almost_full(c0_fiu_af),
        .alloc_valid(c0_alloc_valid),
        .alloc_idx(c0_alloc_idx),
        .almost_full(c0_tx_almost_full),
        .fill_valid(c0_fill_valid),
        .fill_idx(c0_fill_idx),
        .fill_payload(c0_fill_data),
        .rsp_valid(c0_rx_valid),
        .rsp_payload(c0_rx_data),
        .rsp_mdata(c0_rx_mdata)
    );

    // ========================================
    // Write channel reorder buffer
    // ========================================

    ccip_rob
    #(
        .payload_t(ccip_wr_rsp_t)
    )
    rob_wr
    (
        .clk,
        .reset,
        .req_valid(c1_tx_valid),
        .req_mdata(c1_tx_mdata),
        .fiu_almost_full(c1_fiu_af),
        .alloc_valid(c1_alloc_valid),
        .alloc_idx(c1_alloc_idx),
        .almost_full(c1_tx_almost_full),
        .fill_valid(c1_fill_valid),
        .fill_idx(c1_fill_idx),
        .fill_payload(c1_fill_rsp),
        .rsp_valid(c1_rx_valid),
        .rsp_payload(c1_rx_rsp),
        .rsp_mdata(c1_rx_mdata)
    );

    assign c1_rx_hit_miss = c1_rx_rsp.hit_miss;
    assign c1_rx_vc_used = c1_rx_rsp.vc_used;

    // ========================================
    // FIU-side timing registers
    // ========================================

    // Address and data bypass the reorder buffers and join their slot
    // index here, since the buffers rename in the same cycle
    ccip_reg_stage
    #(
        .N_STAGES(N_STAGES)
    )
    reg_stage
    (
        .clk,
        .reset,
        .c0_alloc_valid,
        .c0_alloc_idx,
        .c0_addr(c0_tx_addr),
        .c1_alloc_valid,
        .c1_alloc_idx,
        .c1_addr(c1_tx_addr),
        .c1_data(c1_tx_data),
        .fiu_c0_rx_valid,
        .fiu_c0_rx_mdata,
        .fiu_c0_rx_data,
        .fiu_c1_rx_valid,
        .fiu_c1_rx_mdata,
        .fiu_c1_rx_hit_miss,
        .fiu_c1_rx_vc_used,
        .fiu_c0_almost_full,
        .fiu_c1_almost_full,
        .fiu_c0_tx_valid,
        .fiu_c0_tx_addr,
        .fiu_c0_tx_mdata,
        .fiu_c1_tx_valid,
        .fiu_c1_tx_addr,
        .fiu_c1_tx_data,
        .fiu_c1_tx_mdata,
        .c0_fill_valid,
        .c0_fill_idx,
        .c0_fill_data,
        .c1_fill_valid,
        .c1_fill_idx,
        .c1_fill_rsp,
        .c0_fiu_af,
        .c1_fiu_af
    );

endmodule

//--- test/host_chan_as_ccip_tb_checks.svh
`ifndef HOST_CHAN_AS_CCIP_TB_CHECKS_SVH
`define HOST_CHAN_AS_CCIP_TB_CHECKS_SVH

// Checks found wrong so far, timeouts included
int errors = 0;

// Tags and addresses of requests the AFU has issued, oldest first
ccip_mdata_t exp_rd_tag [$];
ccip_addr_t exp_rd_addr [$];
ccip_mdata_t exp_wr_tag [$];

// Request fields the FIU port should carry, oldest first
ccip_addr_t fiu_rd_addr [$];
ccip_addr_t fiu_wr_addr [$];
ccip_line_t fiu_wr_data [$];

// Write response fields the host chose, keyed by the order the writes reached it
// The shim keeps request order toward the host, so the same key works at the AFU
ccip_wr_rsp_t wr_rsp_by_seq [int];
int wr_rsp_seq = 0;

// One 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// Read data the host returns for an address
// The address is spread over the line and then scrambled by one 64-bit xorshift step
function automatic ccip_line_t read_line(input ccip_addr_t addr);
    logic [63:0] x;
    x = {addr, ~addr, addr ^ 16'h5a5a, addr ^ 16'hf0f0};
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    return x;
endfunction

// Read request at the FIU port against the oldest read the AFU issued
// Slots are taken in turn from zero, so the request count gives the slot
task automatic compare_fiu_read(input ccip_addr_t got_addr, input ccip_mdata_t got_mdata,
                                input int seq);
    ccip_addr_t addr;
    ccip_mdata_t slot;
    if (fiu_rd_addr.size() == 0)
    begin
        $display("A read request reached the FIU with no read issued at %0t", $time);
        errors++;
        return;
    end
    addr = fiu_rd_addr.pop_front();
    slot = ccip_mdata_t'(seq % DEPTH);
    if (got_addr !== addr)
    begin
        $display("FAIL %0t: FIU read address %h, expected %h", $time, got_addr, addr);
        errors++;
    end
    if (got_mdata !== slot)
    begin
        $display("FAIL %0t: FIU read tag %h, expected slot %h", $time, got_mdata, slot);
        errors++;
    end
endtask

// Write request at the FIU port against the oldest write the AFU issued
task automatic compare_fiu_write(input ccip_addr_t got_addr, input ccip_line_t got_data,
                                 input ccip_mdata_t got_mdata, input int seq);
    ccip_addr_t addr;
    ccip_line_t data;
    ccip_mdata_t slot;
    if (fiu_wr_addr.size() == 0)
    begin
        $display("A write request reached the FIU with no write issued at %0t", $time);
        errors++;
        return;
    end
    addr = fiu_wr_addr.pop_front();
    data = fiu_wr_data.pop_front();
    slot = ccip_mdata_t'(seq % DEPTH);
    if (got_addr !== addr)
    begin
        $display("FAIL %0t: FIU write address %h, expected %h", $time, got_addr, addr);
        errors++;
    end
    if (got_data !== data)
    begin
        $display("FAIL %0t: FIU write data %h, expected %h", $time, got_data, data);
        errors++;
    end
    if (got_mdata !== slot)
    begin
        $display("FAIL %0t: FIU write tag %h, expected slot %h", $time, got_mdata, slot);
        errors++;
    end
endtask

// Next read response against the oldest read the AFU issued
task automatic compare_read(input ccip_line_t got_data, input ccip_mdata_t got_mdata);
    ccip_mdata_t tag;
    ccip_line_t data;
    if (exp_rd_tag.size() == 0)
    begin
        $display("A read response came back with no read outstanding at %0t", $time);
        errors++;
        return;
    end
    tag = exp_rd_tag.pop_front();
    data = read_line(exp_rd_addr.pop_front());
    if (got_mdata !== tag)
    begin
        $display("FAIL %0t: read tag %h, expected %h", $time, got_mdata, tag);
        errors++;
    end
    if (got_data !== data)
    begin
        $display("FAIL %0t: read data %h for tag %h, expected %h", $time, got_data, tag, data);
        errors++;
    end
endtask

// Next write response against the oldest write and the fields the host gave it
task automatic compare_write(input ccip_wr_rsp_t got_rsp, input ccip_mdata_t got_mdata);
    ccip_mdata_t tag;
    ccip_wr_rsp_t rsp;
    if (exp_wr_tag.size() == 0 || !wr_rsp_by_seq.exists(wr_rsp_seq))
    begin
        $display("A write response came back before the host answered any such write at %0t",
                 $time);
        errors++;
        return;
    end
    tag = exp_wr_tag.pop_front();
    rsp = wr_rsp_by_seq[wr_rsp_seq];
    wr_rsp_seq++;
    if (got_mdata !== tag)
    begin
        $display("FAIL %0t: write tag %h, expected %h", $time, got_mdata, tag);
        errors++;
    end
    if (got_rsp !== rsp)
    begin
        $display("FAIL %0t: write response %b for tag %h, expected %b", $time, got_rsp, tag, rsp);
        errors++;
    end
endtask

// Single-bit status outputs such as valid and almost-full levels
task automatic compare_level(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
        $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
        errors++;
    end
endtask

`endif

//--- test/host_chan_as_ccip_tb.sv
`timescale 1ns/1ps

`include "ccip_shim_macros.svh"

module host_chan_as_ccip_tb;

    import ccip_shim_pkg::*;

    localparam int DEPTH = `CCIP_ROB_DEPTH;
    localparam int N_STAGES = `CCIP_REG_STAGES;
    localparam logic [31:0] SEED = 32'd20;
    localparam int TRAFFIC_LIMIT = 5000;

    logic clk = 1'b0;
    logic reset;

    // AFU side of the DUT
    logic c0_tx_valid;
    ccip_addr_t c0_tx_addr;
    ccip_mdata_t c0_tx_mdata;
    logic c1_tx_valid;
    ccip_addr_t c1_tx_addr;
    ccip_line_t c1_tx_data;
    ccip_mdata_t c1_tx_mdata;
    logic c0_rx_valid;
    ccip_line_t c0_rx_data;
    ccip_mdata_t c0_rx_mdata;
    logic c1_rx_valid;
    logic c1_rx_hit_miss;
    logic [1:0] c1_rx_vc_used;
    ccip_mdata_t c1_rx_mdata;
    logic c0_tx_almost_full;
    logic c1_tx_almost_full;

    // FIU side of the DUT
    logic fiu_c0_tx_valid;
    ccip_addr_t fiu_c0_tx_addr;
    ccip_mdata_t fiu_c0_tx_mdata;
    logic fiu_c1_tx_valid;
    ccip_addr_t fiu_c1_tx_addr;
    ccip_line_t fiu_c1_tx_data;
    ccip_mdata_t fiu_c1_tx_mdata;
    logic fiu_c0_rx_valid;
    ccip_line_t fiu_c0_rx_data;
    ccip_mdata_t fiu_c0_rx_mdata;
    logic fiu_c1_rx_valid;
    logic fiu_c1_rx_hit_miss;
    logic [1:0] fiu_c1_rx_vc_used;
    ccip_mdata_t fiu_c1_rx_mdata;
    logic fiu_c0_almost_full;
    logic fiu_c1_almost_full;

    // AFU model state, requests still to issue and running counts
    int rd_left = 0;
    int wr_left = 0;
    int rd_issued = 0;
    int wr_issued = 0;
    int rd_done = 0;
    int wr_done = 0;
    ccip_mdata_t next_tag = '0;
    logic [31:0] afu_rng;
    ccip_wr_rsp_t rx_wr;

    // Host model state, requests seen on the FIU port and not yet answered
    logic host_hold = 1'b0;
    logic [31:0] host_rng;
    int rd_seen = 0;
    int wr_seen = 0;
    int pick;
    ccip_wr_rsp_t host_wr;
    logic [`CCIP_ROB_IDX_W-1:0] rd_pend_slot [$];
    ccip_addr_t rd_pend_addr [$];
    logic [`CCIP_ROB_IDX_W-1:0] wr_pend_slot [$];
    int wr_pend_seq [$];

    // Sequence bookkeeping
    int test_errors;
    int failed_tests = 0;
    int rd_target;
    int wr_target;
    int cycles;

    `include "host_chan_as_ccip_tb_checks.svh"

    host_chan_as_ccip #(.N_STAGES(N_STAGES)) uut (.*);

    always #20 clk = ~clk;

    // ========================================
    // AFU model
    // ========================================

    // Own count of reads in flight keeps the AFU from overrunning the buffer,
    // since almost_full is seen one cycle late
    always @(posedge clk)
    begin
        c0_tx_valid <= 1'b0;
        c1_tx_valid <= 1'b0;
        if (!reset)
        begin
            afu_rng = xorshift32(afu_rng);
            if (rd_left > 0 && !c0_tx_almost_full && rd_issued - rd_done < DEPTH && afu_rng[0])
            begin
                c0_tx_valid <= 1'b1;
                c0_tx_addr <= afu_rng[31:16];
                c0_tx_mdata <= next_tag;
                exp_rd_tag.push_back(next_tag);
                exp_rd_addr.push_back(afu_rng[31:16]);
                fiu_rd_addr.push_back(afu_rng[31:16]);
                next_tag++;
                rd_left--;
                rd_issued++;
            end
            if (wr_left > 0 && !c1_tx_almost_full && wr_issued - wr_done < DEPTH && afu_rng[1])
            begin
                c1_tx_valid <= 1'b1;
                c1_tx_addr <= afu_rng[23:8];
                c1_tx_data <= {afu_rng, ~afu_rng};
                c1_tx_mdata <= next_tag;
                exp_wr_tag.push_back(next_tag);
                fiu_wr_addr.push_back(afu_rng[23:8]);
                fiu_wr_data.push_back({afu_rng, ~afu_rng});
                next_tag++;
                wr_left--;
                wr_issued++;
            end
        end
    end

    // Responses toward the AFU are checked as they arrive
    always @(posedge clk)
    begin
        if (!reset && c0_rx_valid)
        begin
            compare_read(c0_rx_data, c0_rx_mdata);
            rd_done++;
        end
        if (!reset && c1_rx_valid)
        begin
            rx_wr.hit_miss = c1_rx_hit_miss;
            rx_wr.vc_used = c1_rx_vc_used;
            compare_write(rx_wr, c1_rx_mdata);
            wr_done++;
        end
    end

    // ========================================
    // Host model
    // ========================================

    // Answers a random pending request on each channel after a random wait
    always @(posedge clk)
    begin
        fiu_c0_rx_valid <= 1'b0;
        fiu_c1_rx_valid <= 1'b0;
        if (!reset)
        begin
            if (fiu_c0_tx_valid)
            begin
                compare_fiu_read(fiu_c0_tx_addr, fiu_c0_tx_mdata, rd_seen);
                rd_seen++;
                rd_pend_slot.push_back(fiu_c0_tx_mdata[`CCIP_ROB_IDX_W-1:0]);
                rd_pend_addr.push_back(fiu_c0_tx_addr);
            end
            if (fiu_c1_tx_valid)
            begin
                compare_fiu_write(fiu_c1_tx_addr, fiu_c1_tx_data, fiu_c1_tx_mdata, wr_seen);
                wr_pend_slot.push_back(fiu_c1_tx_mdata[`CCIP_ROB_IDX_W-1:0]);
                wr_pend_seq.push_back(wr_seen);
                wr_seen++;
            end
            host_rng = xorshift32(host_rng);
            if (!host_hold && rd_pend_slot.size() > 0 && host_rng[1:0] != 2'b00)
            begin
                pick = int'(host_rng[31:16]) % rd_pend_slot.size();
                fiu_c0_rx_valid <= 1'b1;
                fiu_c0_rx_mdata <= ccip_mdata_t'(rd_pend_slot[pick]);
                fiu_c0_rx_data <= read_line(rd_pend_addr[pick]);
                rd_pend_slot.delete(pick);
                rd_pend_addr.delete(pick);
            end
            host_rng = xorshift32(host_rng);
            if (!host_hold && wr_pend_slot.size() > 0 && host_rng[1:0] != 2'b00)
            begin
                pick = int'(host_rng[31:16]) % wr_pend_slot.size();
                host_wr.hit_miss = host_rng[4];
                host_wr.vc_used = host_rng[6:5];
                wr_rsp_by_seq[wr_pend_seq[pick]] = host_wr;
                fiu_c1_rx_valid <= 1'b1;
                fiu_c1_rx_mdata <= ccip_mdata_t'(wr_pend_slot[pick]);
                fiu_c1_rx_hit_miss <= host_wr.hit_miss;
                fiu_c1_rx_vc_used <= host_wr.vc_used;
                wr_pend_slot.delete(pick);
                wr_pend_seq.delete(pick);
            end
        end
    end

    // Waits until the AFU has all responses up to the given counts
    task automatic wait_traffic(input int rd_want, input int wr_want, input string what);
        int n;
        n = 0;
        while ((rd_done < rd_want || wr_done < wr_want) && n < TRAFFIC_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (rd_done < rd_want || wr_done < wr_want)
        begin
            $display("Timed out in %s with %0d of %0d reads and %0d of %0d writes answered",
                     what, rd_done, rd_want, wr_done, wr_want);
            errors++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int errors_before);
        if (errors == errors_before)
        begin
            $display("Test %0d %s: ok", num, name);
        end
        else
        begin
            $display("Test %0d %s: %0d errors", num, name, errors - errors_before);
            failed_tests++;
        end
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial
    begin
        reset = 1'b1;
        c0_tx_valid = 1'b0;
        c0_tx_addr = '0;
        c0_tx_mdata = '0;
        c1_tx_valid = 1'b0;
        c1_tx_addr = '0;
        c1_tx_data = '0;
        c1_tx_mdata = '0;
        fiu_c0_rx_valid = 1'b0;
        fiu_c0_rx_data = '0;
        fiu_c0_rx_mdata = '0;
        fiu_c1_rx_valid = 1'b0;
        fiu_c1_rx_hit_miss = 1'b0;
        fiu_c1_rx_vc_used = '0;
        fiu_c1_rx_mdata = '0;
        fiu_c0_almost_full = 1'b0;
        fiu_c1_almost_full = 1'b0;
        afu_rng = SEED;
        host_rng = xorshift32(SEED ^ 32'h9e3779b9);
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // Outputs straight out of reset
        test_errors = errors;
        @(negedge clk);
        compare_level("c0_rx_valid", c0_rx_valid, 1'b0);
        compare_level("c1_rx_valid", c1_rx_valid, 1'b0);
        compare_level("fiu_c0_tx_valid", fiu_c0_tx_valid, 1'b0);
        compare_level("fiu_c1_tx_valid", fiu_c1_tx_valid, 1'b0);
        compare_level("c0_tx_almost_full", c0_tx_almost_full, 1'b0);
        compare_level("c1_tx_almost_full", c1_tx_almost_full, 1'b0);
        report_test(1, "reset state", test_errors);

        test_errors = errors;
        rd_target = rd_issued + 200;
        rd_left = 200;
        wait_traffic(rd_target, wr_done, "read ordering");
        report_test(2, "read ordering", test_errors);

        test_errors = errors;
        wr_target = wr_issued + 200;
        wr_left = 200;
        wait_traffic(rd_done, wr_target, "write ordering");
        report_test(3, "write ordering", test_errors);

        // Host holds every read until all slots are taken
        test_errors = errors;
        host_hold = 1'b1;
        rd_target = rd_issued + DEPTH;
        rd_left = DEPTH;
        cycles = 0;
        while (!c0_tx_almost_full && cycles < 500)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!c0_tx_almost_full)
        begin
            $display("c0_tx_almost_full never rose with reads held by the host");
            errors++;
        end
        else if (rd_issued != rd_target)
        begin
            $display("FAIL %0t: almost_full rose with %0d of %0d reads outstanding",
                     $time, rd_issued + DEPTH - rd_target, DEPTH);
            errors++;
        end
        host_hold = 1'b0;
        wait_traffic(rd_target, wr_done, "buffer full");
        compare_level("c0_tx_almost_full after drain", c0_tx_almost_full, 1'b0);
        report_test(4, "buffer full", test_errors);

        // FIU almost-full on the write channel, with mixed traffic behind it
        test_errors = errors;
        @(posedge clk);
        fiu_c1_almost_full <= 1'b1;
        cycles = 0;
        // The first negedge comes before the DUT has sampled the new level
        while (!c1_tx_almost_full && cycles <= N_STAGES)
        begin
            @(negedge clk);
            cycles++;
        end
        compare_level("c1_tx_almost_full after fiu_c1_almost_full", c1_tx_almost_full, 1'b1);
        rd_target = rd_issued + 60;
        wr_target = wr_issued + 60;
        rd_left = 60;
        wr_left = 60;
        repeat (40) @(negedge clk);
        @(posedge clk);
        fiu_c1_almost_full <= 1'b0;
        wait_traffic(rd_target, wr_target, "FIU almost full");
        if (exp_rd_tag.size() != 0 || exp_wr_tag.size() != 0)
        begin
            $display("Requests were left without a response after the mixed traffic");
            errors++;
        end
        report_test(5, "FIU almost full", test_errors);

        $display("Tests run 5, tests failed %0d, errors %0d", failed_tests, errors);
        if (errors == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule
